//--- files.f
verilog/bkram_pkg.sv
verilog/nv_port_if.sv
verilog/bk_arm.sv
verilog/bk_buffer.sv
verilog/bk_sequencer.sv
verilog/bk_top.sv
tb/tb_bk_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the backup RAM testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_bk_top -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_bk_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" sim.log; then
	exit 0
fi

echo "Pass message not found in sim.log"
exit 1

//--- tb/tb_bk_top.sv
// Testbench for the backup RAM save and load engine
//   clock, reset and stimulus for the bk_top DUT
//   SD host model answering sector requests
//   xorshift data and a byte model of the backup RAM
//   concurrent and immediate checks

module tb_bk_top;
	timeunit 1ns;
	timeprecision 1ps;

	logic        clk_sys, reset;
	logic        download, img_mounted, img_readonly;
	logic [63:0] img_size;
	logic        load_cmd, save_cmd, autosave, osd_status;
	logic [14:0] nv_addr;
	logic        nv_we;
	logic [7:0]  nv_d, nv_q;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout, sd_buff_din;
	logic        bk_busy, bk_loading, led_user;

	// Expected backup RAM contents
	logic [7:0]  exp_mem [32768];
	logic [31:0] rng;
	int          sectors_done;

	bk_top u_bk_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Protocol checks
	// ============================================================

	assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else abort_run("sd_rd and sd_wr are high at the same time");

	assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> u_bk_top.bk_ena)
		else abort_run("SD request raised while backup is disabled");

	// LBA seen by the host follows the completed sectors
	assert property (@(posedge clk_sys) disable iff (reset)
		(bk_busy && sd_ack) |-> (sd_lba == sectors_done))
		else report_mismatch("lba_tracking", 64'($sampled(sectors_done)),
			64'($sampled(sd_lba)));

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		abort_run($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
			name, exp, got));
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		assert (got === exp)
			else report_mismatch(name, exp, got);
	endtask

	// Inputs change 1 ns after the edge
	task automatic next_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic wait_request(input logic is_load);
		int t = 0;
		while (!(sd_rd || sd_wr)) begin
			next_cycles(1);
			t++;
			if (t > 100)
				abort_run("timeout waiting for an SD request");
		end
		check_value("request_rd", 64'(is_load), 64'(sd_rd));
		check_value("request_wr", 64'(!is_load), 64'(sd_wr));
	endtask

	task automatic wait_idle();
		int t = 0;
		while (bk_busy) begin
			next_cycles(1);
			t++;
			if (t > 100)
				abort_run("timeout waiting for bk_busy to fall");
		end
	endtask

	// Commands and a game write in the same cycle
	task automatic pulse_commands_and_write();
		load_cmd = 1'b1;
		save_cmd = 1'b1;
		nv_we    = 1'b1;
		next_cycles(1);
		load_cmd = 1'b0;
		save_cmd = 1'b0;
		nv_we    = 1'b0;
	endtask

	task automatic expect_quiet(input string name);
		for (int i = 0; i < 200; i++) begin
			next_cycles(1);
			check_value(name, 64'd0, 64'({sd_rd, sd_wr, led_user}));
		end
	endtask

	// SD host, 64 sectors in one direction
	task automatic serve_transfer(input logic is_load);
		logic [14:0] a;
		sectors_done = 0;
		for (int s = 0; s < bkram_pkg::SECTOR_COUNT; s++) begin
			wait_request(is_load);
			check_value("request_lba", 64'(s), 64'(sd_lba));
			check_value("loading", 64'(is_load), 64'(bk_loading));
			next_cycles(3);
			sd_ack = 1'b1;
			for (int o = 0; o < bkram_pkg::SECTOR_BYTES; o++) begin
				a            = 15'(s * bkram_pkg::SECTOR_BYTES + o);
				sd_buff_addr = 9'(o);
				sd_buff_wr   = is_load;
				sd_buff_dout = exp_mem[a];
				next_cycles(1);
				// Read data is registered one cycle after the address
				if (!is_load)
					check_value("save_data", 64'(exp_mem[a]), 64'(sd_buff_din));
				if (o == 1)
					check_value("request_drop", 64'd0, 64'({sd_rd, sd_wr}));
			end
			sd_ack       = 1'b0;
			sd_buff_wr   = 1'b0;
			sectors_done = sectors_done + 1;
		end
		wait_idle();
		check_value("end_state", 64'd0, 64'({bk_busy, bk_loading}));
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin
		reset        = 1'b1;
		download     = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'd0;
		load_cmd     = 1'b0;
		save_cmd     = 1'b0;
		autosave     = 1'b0;
		osd_status   = 1'b0;
		nv_addr      = 15'd0;
		nv_we        = 1'b0;
		nv_d         = 8'd0;
		sd_ack       = 1'b0;
		sd_buff_addr = 9'd0;
		sd_buff_dout = 8'd0;
		sd_buff_wr   = 1'b0;
		sectors_done = 0;
		rng          = 32'd8226;
		next_cycles(5);
		reset = 1'b0;
		check_value("reset_state", 64'd0, 64'({bk_busy, bk_loading, sd_rd, sd_wr, led_user,
			u_bk_top.bk_ena, u_bk_top.bk_pending}));
		check_value("reset_lba", 64'd0, 64'(sd_lba));

		// Enable gating, no image then a read-only image
		autosave = 1'b1;
		pulse_commands_and_write();
		expect_quiet("gate_no_image");
		img_mounted  = 1'b1;
		img_readonly = 1'b1;
		download     = 1'b1;
		next_cycles(10);
		img_size = 64'd32768;
		download = 1'b0;
		next_cycles(2);
		pulse_commands_and_write();
		expect_quiet("gate_read_only");

		// Autoload of a writable image
		autosave = 1'b0;
		for (int i = 0; i < bkram_pkg::NV_BYTES; i++) begin
			rng = xorshift32(rng);
			exp_mem[15'(i)] = rng[7:0];
		end
		img_readonly = 1'b0;
		download     = 1'b1;
		next_cycles(10);
		download = 1'b0;
		serve_transfer(1'b1);

		// Loaded bytes on the game port
		for (int i = 0; i < 64; i++) begin
			rng = xorshift32(rng);
			nv_addr = rng[14:0];
			next_cycles(1);
			check_value("load_contents", 64'(exp_mem[rng[14:0]]), 64'(nv_q));
		end

		// Manual save after game writes
		for (int i = 0; i < 32; i++) begin
			rng = xorshift32(rng);
			nv_addr = rng[14:0];
			nv_d    = rng[23:16];
			nv_we   = 1'b1;
			exp_mem[rng[14:0]] = rng[23:16];
			next_cycles(1);
		end
		nv_we    = 1'b0;
		save_cmd = 1'b1;
		next_cycles(1);
		save_cmd = 1'b0;
		next_cycles(1);
		check_value("save_start_early", 64'd0, 64'(sd_wr));
		next_cycles(1);
		check_value("save_start", 64'd3, 64'({sd_wr, bk_busy}));
		serve_transfer(1'b0);

		// Autosave when the menu opens
		autosave = 1'b1;
		rng = xorshift32(rng);
		nv_addr = rng[14:0];
		nv_d    = rng[23:16];
		nv_we   = 1'b1;
		exp_mem[rng[14:0]] = rng[23:16];
		next_cycles(1);
		nv_we = 1'b0;
		check_value("autosave_led_on", 64'd1, 64'(led_user));
		osd_status = 1'b1;
		serve_transfer(1'b0);
		check_value("autosave_led_off", 64'd0, 64'(led_user));
		osd_status = 1'b0;
		next_cycles(2);

		// Load and save commands together while enabled, load wins
		pulse_commands_and_write();
		serve_transfer(1'b1);

		$display("Test passed");
		$finish;
	end

endmodule

//--- verilog/bk_arm.sv
// Backup enable and game-side tracking
//   download edge register
//   backup enable from a writable image mounted during download
//   pending-write flag for autosave
//   autoload pulse after download ends
//   game RAM port onto the buffer interface

module bk_arm (
	input  logic                clk_sys,
	input  logic                reset,

	input  logic                download,
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic                osd_status,
	input  logic [63:0]         img_size,

	// Game side RAM port
	input  bkram_pkg::nv_addr_t nv_addr,
	input  logic                nv_we,
	input  bkram_pkg::byte_t    nv_d,
	output bkram_pkg::byte_t    nv_q,

	nv_port_if.user             game_port,

	input  logic                bk_busy,
	output logic                bk_ena,
	output logic                bk_pending,
	output logic                autoload
);

	logic download_q;
	logic download_rise;
	logic download_fall;

	assign download_rise = download & ~download_q;
	assign download_fall = ~download & download_q;

	// ============================================================
	// Game port
	// ============================================================

	assign game_port.addr = nv_addr;
	assign game_port.we   = nv_we;
	assign game_port.d    = nv_d;
	assign nv_q           = game_port.q;

	// ============================================================
	// Enable, pending and autoload
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
			autoload   <= 1'b0;
		end else begin
			download_q <= download;

			// New cartridge drops the old save until its image shows up
			if (download_rise)
				bk_ena <= 1'b0;
			// Save image is mounted before the download finishes
			if (download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			// Game wrote to backup RAM since the last transfer
			if (bk_ena && !osd_status && nv_we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;

			autoload <= download_fall && (|img_size) && bk_ena;
		end
	end

endmodule

//--- verilog/bk_buffer.sv
// Backup RAM array
//   true dual-port byte RAM, game port and SD port
//   independent write and registered read on each port

module bk_buffer (
	input  logic   clk_sys,

	nv_port_if.mem game_port,
	nv_port_if.mem sd_port
);

	// ============================================================
	// Storage
	// ============================================================

	// SECTOR_COUNT sectors of SECTOR_BYTES each
	bkram_pkg::byte_t mem [bkram_pkg::NV_BYTES];

	bkram_pkg::byte_t game_q;
	bkram_pkg::byte_t sd_q;

	// ============================================================
	// Ports
	// ============================================================

	// Both ports share one clock
	always_ff @(posedge clk_sys) begin
		// Game side
		if (game_port.we)
			mem[game_port.addr] <= game_port.d;
		game_q <= mem[game_port.addr];

		// SD side
		if (sd_port.we)
			mem[sd_port.addr] <= sd_port.d;
		sd_q <= mem[sd_port.addr];
	end

	assign game_port.q = game_q;
	assign sd_port.q   = sd_q;

endmodule

//--- verilog/bk_sequencer.sv
// Sector transfer sequencer
//   load and save command edge detection
//   autosave trigger from pending writes and menu open
//   idle, load and save state machine over 64 sectors
//   SD request and acknowledge handling
//   SD buffer side of the backup RAM

module bk_sequencer (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  bk_ena,
	input  logic                  bk_pending,
	input  logic                  autoload,

	input  logic                  load_cmd,
	input  logic                  save_cmd,
	input  logic                  autosave,
	input  logic                  osd_status,

	output logic                  bk_busy,
	output logic                  bk_loading,

	// SD host side
	output bkram_pkg::lba_t       sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	input  bkram_pkg::buff_addr_t sd_buff_addr,
	input  bkram_pkg::byte_t      sd_buff_dout,
	input  logic                  sd_buff_wr,
	output bkram_pkg::byte_t      sd_buff_din,

	nv_port_if.user               sd_port
);

	bkram_pkg::bk_state_t state;
	bkram_pkg::sector_t   sector;

	logic save_req;
	logic load_q, load_qq;
	logic save_q, save_qq;
	logic load_pulse, save_pulse;
	logic ack_q;
	logic ack_rise, ack_fall;
	logic last_sector;

	// Manual save, or autosave when the menu opens with unsaved writes
	assign save_req = save_cmd | (bk_pending & osd_status & autosave);

	assign ack_rise    = sd_ack & ~ack_q;
	assign ack_fall    = ~sd_ack & ack_q;
	assign sector      = bkram_pkg::sector_t'(sd_lba[bkram_pkg::SECTOR_AW-1:0]);
	assign last_sector = (sector == bkram_pkg::sector_t'(bkram_pkg::SECTOR_COUNT - 1));

	// ============================================================
	// Command edges
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q     <= 1'b0;
			load_qq    <= 1'b0;
			save_q     <= 1'b0;
			save_qq    <= 1'b0;
			load_pulse <= 1'b0;
			save_pulse <= 1'b0;
		end else begin
			load_q     <= load_cmd & bk_ena;
			load_qq    <= load_q;
			save_q     <= save_req & bk_ena;
			save_qq    <= save_q;
			load_pulse <= load_q & ~load_qq;
			save_pulse <= save_q & ~save_qq;
		end
	end

	// ============================================================
	// Sector state machine
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= bkram_pkg::BK_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bkram_pkg::BK_IDLE: begin
					// Load wins over a save in the same cycle
					if (load_pulse || autoload) begin
						state  <= bkram_pkg::BK_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
						sd_wr  <= 1'b0;
					end else if (save_pulse) begin
						state  <= bkram_pkg::BK_SAVE;
						sd_lba <= '0;
						sd_rd  <= 1'b0;
						sd_wr  <= 1'b1;
					end
				end

				bkram_pkg::BK_LOAD, bkram_pkg::BK_SAVE: begin
					// End of one sector
					if (ack_fall) begin
						if (last_sector) begin
							state <= bkram_pkg::BK_IDLE;
						end else begin
							sd_lba <= sd_lba + bkram_pkg::lba_t'(1);
							sd_rd  <= (state == bkram_pkg::BK_LOAD);
							sd_wr  <= (state == bkram_pkg::BK_SAVE);
						end
					end
				end

				default: state <= bkram_pkg::BK_IDLE;
			endcase
		end
	end

	assign bk_busy    = (state != bkram_pkg::BK_IDLE);
	assign bk_loading = (state == bkram_pkg::BK_LOAD);

	// ============================================================
	// SD buffer port
	// ============================================================

	assign sd_port.addr = {sector, sd_buff_addr};
	// Only a load writes into the backup RAM
	assign sd_port.we   = sd_buff_wr & sd_ack & bk_loading;
	assign sd_port.d    = sd_buff_dout;
	assign sd_buff_din  = sd_port.q;

endmodule

//--- verilog/bk_top.sv
// Backup RAM save and load engine, top level
//   game port tracking and backup enable
//   dual-port backup RAM
//   sector sequencer to the SD host
//   user LED

module bk_top (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  download,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [63:0]           img_size,

	input  logic                  load_cmd,
	input  logic                  save_cmd,
	input  logic                  autosave,
	input  logic                  osd_status,

	// Game side RAM port
	input  bkram_pkg::nv_addr_t   nv_addr,
	input  logic                  nv_we,
	input  bkram_pkg::byte_t      nv_d,
	output bkram_pkg::byte_t      nv_q,

	// SD host
	output bkram_pkg::lba_t       sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	input  bkram_pkg::buff_addr_t sd_buff_addr,
	input  bkram_pkg::byte_t      sd_buff_dout,
	output bkram_pkg::byte_t      sd_buff_din,
	input  logic                  sd_buff_wr,

	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  led_user
);

	logic bk_ena;
	logic bk_pending;
	logic autoload;

	nv_port_if game_port ();
	nv_port_if sd_port ();

	// ============================================================
	// Blocks
	// ============================================================

	bk_arm u_bk_arm (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.img_size     (img_size),
		.nv_addr      (nv_addr),
		.nv_we        (nv_we),
		.nv_d         (nv_d),
		.nv_q         (nv_q),
		.game_port    (game_port),
		.bk_busy      (bk_busy),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.autoload     (autoload)
	);

	bk_buffer u_bk_buffer (
		.clk_sys   (clk_sys),
		.game_port (game_port),
		.sd_port   (sd_port)
	);

	bk_sequencer u_bk_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.autoload     (autoload),
		.load_cmd     (load_cmd),
		.save_cmd     (save_cmd),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din),
		.sd_port      (sd_port)
	);

	// Lit while downloading, transferring, or holding unsaved writes
	assign led_user = download | bk_busy | (autosave & bk_pending);

endmodule

//--- verilog/bkram_pkg.sv
// Backup RAM save and load engine, shared definitions
//   sizes of the SD sector image and the backup RAM
//   vector types for bytes, addresses and block numbers
//   sector sequencer state encoding

package bkram_pkg;

	// ============================================================
	// Sizes
	// ============================================================

	// Bytes in one SD sector, also the host buffer size
	localparam int SECTOR_BYTES = 512;
	// Sectors in the backup image
	localparam int SECTOR_COUNT = 64;

	localparam int BUFF_AW   = $clog2(SECTOR_BYTES);
	localparam int SECTOR_AW = $clog2(SECTOR_COUNT);
	localparam int NV_AW     = SECTOR_AW + BUFF_AW;
	localparam int NV_BYTES  = SECTOR_COUNT * SECTOR_BYTES;

	// ============================================================
	// Vector types
	// ============================================================

	// Data byte on either RAM port or the SD buffer
	typedef logic [7:0] byte_t;

	// Offset inside one sector
	typedef logic [BUFF_AW-1:0] buff_addr_t;

	// Sector index, low part of the LBA
	typedef logic [SECTOR_AW-1:0] sector_t;

	// Backup RAM address, sector index then offset
	typedef logic [NV_AW-1:0] nv_addr_t;

	// SD logical block address
	typedef logic [31:0] lba_t;

	// Sequencer states
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_t;

endpackage

//--- verilog/nv_port_if.sv
// Single-cycle backup RAM port
//   address, write enable, write data and read data
//   user side drives the request, mem side returns the byte
// Writes land at the rising edge with we high.
// Read data follows the address by one cycle.

interface nv_port_if;

	// Byte address into the backup RAM
	bkram_pkg::nv_addr_t addr;

	// Write strobe, one byte per cycle
	logic we;

	// Write data
	bkram_pkg::byte_t d;

	// Registered read data
	bkram_pkg::byte_t q;

	// Requesting side
	modport user (
		output addr,
		output we,
		output d,
		input  q
	);

	// RAM side
	modport mem (
		input  addr,
		input  we,
		input  d,
		output q
	);

endinterface
